// ==== sim.f ====
+incdir+bench
hdl/csr_pkg.sv
hdl/csr_access_decode.sv
hdl/csr_machine_regs.sv
hdl/perf_event_select.sv
hdl/perf_counters.sv
hdl/csr_top.sv
bench/csr_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: obj_dir/Vcsr_tb

# rebuilt only when a source, the table or the file list changes
obj_dir/Vcsr_tb: sim.f $(SRCS) bench/csr_tb_table.svh
	verilator --binary --assert -f sim.f --top-module csr_tb -Mdir obj_dir

# status comes from the search for the pass line
run: obj_dir/Vcsr_tb
	@out="$$(./obj_dir/Vcsr_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== bench/csr_tb_table.svh ====
// name, csr addr, op, wdata, exc {save_if,save_id,save_branch,load_event,restore,save_cause}, cause
//   pipe mode, extra cycles, read addr, expected value (USE_MODEL: reference model)
add_row("mepc_write",    ADDR_MEPC,     CSR_OP_WRITE, 32'h0000_1234, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_1234);
add_row("mepc_set",      ADDR_MEPC,     CSR_OP_SET,   32'h0000_F000, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_F234);
add_row("mepc_clear",    ADDR_MEPC,     CSR_OP_CLEAR, 32'h0000_0230, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_F004);
add_row("mepc_none",     ADDR_MEPC,     CSR_OP_NONE,  32'hFFFF_FFFF, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_F004);
add_row("mcause_write",  ADDR_MCAUSE,   CSR_OP_WRITE, 32'hFFFF_FFFF, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MCAUSE,   33'h0_8000_001F);
add_row("mcause_clear",  ADDR_MCAUSE,   CSR_OP_CLEAR, 32'h8000_0010, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MCAUSE,   33'h0_0000_000F);
add_row("mstatus_set",   ADDR_MSTATUS,  CSR_OP_SET,   32'hFFFF_FFFF, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MSTATUS,  33'h0_0000_0088);
add_row("mstatus_clear", ADDR_MSTATUS,  CSR_OP_CLEAR, 32'h0000_0080, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MSTATUS,  33'h0_0000_0008);
// constant registers
add_row("misa_const",    ADDR_MISA,     CSR_OP_NONE,  32'h0000_0000, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MISA,     33'h0_0000_0000);
add_row("mimpid_const",  ADDR_MIMPID,   CSR_OP_NONE,  32'h0000_0000, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MIMPID,   33'h0_0000_8000);
add_row("mhartid_const", ADDR_MHARTID,  CSR_OP_NONE,  32'h0000_0000, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MHARTID,  33'h0_0000_0545);
// exception entry and return
add_row("save_if_cause", ADDR_MCAUSE,   CSR_OP_WRITE, 32'h0000_0005, 6'b100001, 6'h02,
        IDLE,  16'd0,   ADDR_MCAUSE,   33'h0_0000_0002);
add_row("mstatus_saved", ADDR_MSTATUS,  CSR_OP_NONE,  32'h0000_0000, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_MSTATUS,  33'h0_0000_0080);
add_row("mret_restore",  ADDR_MSTATUS,  CSR_OP_NONE,  32'h0000_0000, 6'b000010, 6'h00,
        IDLE,  16'd0,   ADDR_MSTATUS,  33'h0_0000_0088);
add_row("save_branch",   ADDR_MEPC,     CSR_OP_NONE,  32'h0000_0000, 6'b101000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_0200);
add_row("save_id_wins",  ADDR_MEPC,     CSR_OP_WRITE, 32'h0000_1111, 6'b010000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_00FC);
add_row("save_if_pc",    ADDR_MEPC,     CSR_OP_NONE,  32'h0000_0000, 6'b100000, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_0100);
add_row("load_event",    ADDR_MEPC,     CSR_OP_NONE,  32'h0000_0000, 6'b101100, 6'h00,
        IDLE,  16'd0,   ADDR_MEPC,     33'h0_0000_00FC);
// performance counters
add_row("pcer_write",    ADDR_PCER,     CSR_OP_WRITE, 32'h0000_1DEF, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_PCER,     33'h0_0000_1DEF);
add_row("pccr_all_load", ADDR_PCCR_ALL, CSR_OP_WRITE, 32'h0000_0100, 6'b000000, 6'h00,
        SWEEP, 16'd3,   ADDR_PCCR_ALL, USE_MODEL);
add_row("random_count",  ADDR_PCCR_ALL, CSR_OP_WRITE, 32'h0000_0000, 6'b000000, 6'h00,
        RAND,  16'd300, 12'h780,       USE_MODEL);
add_row("count_sweep",   12'h780,       CSR_OP_NONE,  32'h0000_0000, 6'b000000, 6'h00,
        SWEEP, 16'd2,   12'h780,       USE_MODEL);
add_row("pcmr_disable",  ADDR_PCMR,     CSR_OP_WRITE, 32'h0000_0002, 6'b000000, 6'h00,
        RAND,  16'd60,  ADDR_PCMR,     33'h0_0000_0002);
add_row("hold_sweep",    12'h780,       CSR_OP_NONE,  32'h0000_0000, 6'b000000, 6'h00,
        SWEEP, 16'd2,   12'h780,       USE_MODEL);
add_row("pcmr_enable",   ADDR_PCMR,     CSR_OP_WRITE, 32'h0000_0003, 6'b000000, 6'h00,
        IDLE,  16'd0,   ADDR_PCMR,     33'h0_0000_0003);
add_row("sat_hold",      12'h780,       CSR_OP_WRITE, 32'hFFFF_FFFF, 6'b000000, 6'h00,
        IDLE,  16'd5,   12'h780,       33'h0_FFFF_FFFF);
add_row("wrap_off",      ADDR_PCMR,     CSR_OP_WRITE, 32'h0000_0001, 6'b000000, 6'h00,
        IDLE,  16'd1,   12'h780,       33'h0_0000_0000);

// ==== bench/csr_tb.sv ====
`timescale 1ns/1ns

module csr_tb;
  import csr_pkg::*;

  localparam logic [1:0]  IDLE      = 2'd0;   // quiet pipeline
  localparam logic [1:0]  RAND      = 2'd1;   // random pipeline and ext events
  localparam logic [1:0]  SWEEP     = 2'd2;   // quiet, then read all counters
  localparam logic [32:0] USE_MODEL = 33'h1_0000_0000;
  localparam csr_data_t   PC_IF     = 32'h0000_0100;
  localparam csr_data_t   PC_ID     = 32'h0000_00FC;
  localparam csr_data_t   PC_BR     = 32'h0000_0200;

  typedef struct packed {
    csr_addr_t   addr;
    csr_op_t     op;
    csr_data_t   wdata;
    logic [5:0]  exc;      // {if, id, branch, load_event, restore, cause}
    cause_t      cause;
    logic [1:0]  mode;
    logic [15:0] cycles;   // extra cycles before the read
    csr_addr_t   chk;
    logic [32:0] exp;      // bit 32 takes the model value
  } row_t;

  logic                    clk;
  logic                    rst_n;
  logic [3:0]              core_id;
  logic [5:0]              cluster_id;
  csr_req_t                req;
  exc_ctrl_t               exc;
  pipe_status_t            pipe;
  logic [N_EXT_EVENTS-1:0] ext;
  csr_data_t               rdata;
  logic                    irq_enable;
  csr_data_t               mepc;

  row_t  rows[$];
  string names[$];
  int    errors    = 0;
  int    cycle_cnt = 0;
  int    limit     = 0;

  // reference state
  logic      ref_mie;
  logic      ref_mpie;
  csr_data_t ref_mepc;
  cause_t    ref_mcause;
  perf_vec_t ref_pcer;
  logic [1:0] ref_pcmr;
  perf_vec_t ref_pend;      // increments waiting one edge
  logic      ref_idv_q;
  csr_data_t ref_cnt [N_PERF_EVENTS];

  csr_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_id_i     (core_id),
    .cluster_id_i  (cluster_id),
    .csr_req_i     (req),
    .exc_ctrl_i    (exc),
    .pipe_status_i (pipe),
    .ext_events_i  (ext),
    .csr_rdata_o   (rdata),
    .irq_enable_o  (irq_enable),
    .mepc_o        (mepc)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit > 0 && cycle_cnt > limit)
    begin
      $display("timeout: no progress after %0d cycles", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // table
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input csr_addr_t addr, input csr_op_t op,
                         input csr_data_t wdata, input logic [5:0] exc_bits,
                         input cause_t cause, input logic [1:0] mode,
                         input logic [15:0] cycles, input csr_addr_t chk,
                         input logic [32:0] exp);
    row_t r;
    r.addr   = addr;
    r.op     = op;
    r.wdata  = wdata;
    r.exc    = exc_bits;
    r.cause  = cause;
    r.mode   = mode;
    r.cycles = cycles;
    r.chk    = chk;
    r.exp    = exp;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic load_table;
    `include "csr_tb_table.svh"
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic csr_data_t resolve_op(csr_op_t op, csr_data_t wdata, csr_data_t cur);
    if (op == CSR_OP_SET)
      return cur | wdata;
    if (op == CSR_OP_CLEAR)
      return cur & ~wdata;
    return wdata;
  endfunction

  function automatic csr_data_t predict_read(csr_addr_t addr);
    csr_data_t val;
    val = '0;   // misa and unmapped
    if (addr == ADDR_MSTATUS)
      val = {24'b0, ref_mpie, 3'b0, ref_mie, 3'b0};
    else if (addr == ADDR_MEPC)
      val = ref_mepc;
    else if (addr == ADDR_MCAUSE)
      val = {ref_mcause[5], 26'b0, ref_mcause[4:0]};
    else if (addr == ADDR_MIMPID)
      val = 32'h0000_8000;
    else if (addr == ADDR_MHARTID)
      val = {21'b0, cluster_id, 1'b0, core_id};
    else if (addr == ADDR_PCER)
      val = {19'b0, ref_pcer};
    else if (addr == ADDR_PCMR)
      val = {30'b0, ref_pcmr};
    else if (int'(addr) >= 'h780 && int'(addr) < 'h780 + N_PERF_EVENTS)
      val = ref_cnt[int'(addr) - 'h780];
    return val;
  endfunction

  function automatic perf_vec_t qualify_events(pipe_status_t p, logic [N_EXT_EVENTS-1:0] x);
    perf_vec_t ev;
    ev     = '0;
    ev[0]  = 1'b1;                                  // cycles
    ev[1]  = p.id_valid & p.is_decoding;
    ev[2]  = p.ld_stall & ref_idv_q;                // stalls use last id_valid
    ev[3]  = p.jr_stall & ref_idv_q;
    ev[4]  = p.imiss & ~p.pc_set;
    ev[5]  = p.mem_load;
    ev[6]  = p.mem_store;
    ev[7]  = p.jump & ref_idv_q;
    ev[8]  = p.branch & ref_idv_q;
    ev[9]  = p.branch & p.branch_taken & ref_idv_q;
    ev[10] = p.id_valid & p.is_decoding & p.is_compressed;
    ev[N_PERF_EVENTS-N_EXT_EVENTS +: N_EXT_EVENTS] = x;
    return ev;
  endfunction

  // one rising edge with the given inputs
  task automatic advance_reference(csr_req_t r, exc_ctrl_t e, pipe_status_t p,
                                   logic [N_EXT_EVENTS-1:0] x);
    perf_vec_t fire;
    csr_data_t nv;
    csr_data_t old;
    logic      wr;
    logic      mie_old;
    logic      mpie_old;
    fire     = qualify_events(p, x) & ref_pcer & {N_PERF_EVENTS{ref_pcmr[0]}};
    wr       = r.access && (r.op != CSR_OP_NONE);
    nv       = resolve_op(r.op, r.wdata, predict_read(r.addr));
    mie_old  = ref_mie;
    mpie_old = ref_mpie;
    for (int i = 0; i < N_PERF_EVENTS; i++)
    begin
      old = ref_cnt[i];
      if (ref_pend[i] && !(ref_pcmr[1] && old == 32'hFFFF_FFFF))
        ref_cnt[i] = old + 1;
      if (wr && (r.addr == ADDR_PCCR_ALL || int'(r.addr) == 'h780 + i))
        ref_cnt[i] = resolve_op(r.op, r.wdata, old);   // write beats increment
    end
    if (wr && r.addr == ADDR_PCER)
      ref_pcer = nv[N_PERF_EVENTS-1:0];
    if (wr && r.addr == ADDR_PCMR)
      ref_pcmr = nv[1:0];
    if (wr && r.addr == ADDR_MSTATUS)
    begin
      ref_mpie = nv[7];
      ref_mie  = nv[3];
    end
    if (wr && r.addr == ADDR_MEPC)
      ref_mepc = nv;
    if (wr && r.addr == ADDR_MCAUSE)
      ref_mcause = {nv[31], nv[4:0]};
    if (e.save_if || e.save_id || e.save_branch)
    begin
      ref_mpie = mie_old;
      ref_mie  = 1'b0;
      ref_mepc = e.load_event ? e.pc_id : e.save_branch ? e.branch_target :
                 e.save_if ? e.pc_if : e.pc_id;
    end
    if (e.save_cause)
      ref_mcause = e.cause;
    if (e.restore)
    begin
      ref_mie  = mpie_old;
      ref_mpie = mpie_old;
    end
    ref_pend  = fire;
    ref_idv_q = p.id_valid;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  function automatic exc_ctrl_t base_exc();
    exc_ctrl_t e;
    e               = '0;
    e.pc_if         = PC_IF;
    e.pc_id         = PC_ID;
    e.branch_target = PC_BR;
    return e;
  endfunction

  task automatic apply_inputs(csr_req_t r, exc_ctrl_t e, logic rnd_pipe);
    logic [31:0] rnd;
    @(negedge clk);
    req = r;
    exc = e;
    rnd = $urandom;
    pipe = rnd_pipe ? rnd[11:0] : '0;
    ext  = rnd_pipe ? rnd[12 +: N_EXT_EVENTS] : '0;
  endtask

  task automatic run_row(int k);
    row_t      rw;
    csr_req_t  op_req;
    csr_req_t  rd_req;
    exc_ctrl_t op_exc;
    csr_data_t expv;
    int        n_reads;
    int        errs;
    rw           = rows[k];
    errs         = 0;
    op_req       = '{access: 1'b1, addr: rw.addr, op: rw.op, wdata: rw.wdata};
    op_exc       = base_exc();
    op_exc.save_if     = rw.exc[5];
    op_exc.save_id     = rw.exc[4];
    op_exc.save_branch = rw.exc[3];
    op_exc.load_event  = rw.exc[2];
    op_exc.restore     = rw.exc[1];
    op_exc.save_cause  = rw.exc[0];
    op_exc.cause       = rw.cause;
    apply_inputs(op_req, op_exc, rw.mode == RAND);
    advance_reference(req, exc, pipe, ext);
    for (int c = 0; c < int'(rw.cycles); c++)
    begin
      apply_inputs('0, base_exc(), rw.mode == RAND);
      advance_reference(req, exc, pipe, ext);
    end
    n_reads = (rw.mode == SWEEP) ? N_PERF_EVENTS : 1;
    for (int j = 0; j < n_reads; j++)
    begin
      rd_req = '{access: 1'b1, addr: rw.chk, op: CSR_OP_NONE, wdata: '0};
      if (rw.mode == SWEEP)
        rd_req.addr = 12'h780 + 12'(j);
      apply_inputs(rd_req, base_exc(), 1'b0);
      #1;   // read path settled, well before the edge
      expv = (rw.exp[32] || rw.mode == SWEEP) ? predict_read(rd_req.addr) : rw.exp[31:0];
      assert (rdata === expv)
      else
      begin
        $display("mismatch %s @%h: expected %h, actual %h", names[k], rd_req.addr, expv, rdata);
        errs++;
      end
      assert (irq_enable === ref_mie)
      else
      begin
        $display("mismatch %s irq_enable: expected %b, actual %b", names[k], ref_mie,
                 irq_enable);
        errs++;
      end
      assert (mepc === ref_mepc)
      else
      begin
        $display("mismatch %s mepc_o: expected %h, actual %h", names[k], ref_mepc, mepc);
        errs++;
      end
      advance_reference(req, exc, pipe, ext);
    end
    $display("%-16s %s", names[k], (errs == 0) ? "ok" : "FAILED");
    errors += errs;
  endtask

  //////////////////////////////////////////////////
  // main
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h92e3da26));
    rst_n      = 1'b0;
    core_id    = 4'h5;
    cluster_id = 6'h2A;
    req        = '0;
    exc        = '0;
    pipe       = '0;
    ext        = '0;
    ref_mie    = 1'b0;
    ref_mpie   = 1'b0;
    ref_mepc   = '0;
    ref_mcause = '0;
    ref_pcer   = '0;
    ref_pcmr   = 2'b11;   // enabled, saturating
    ref_pend   = '0;
    ref_idv_q  = 1'b0;
    for (int i = 0; i < N_PERF_EVENTS; i++)
      ref_cnt[i] = '0;
    load_table();
    // op, extra cycles and up to a full sweep per row, plus reset and margin
    for (int k = 0; k < rows.size(); k++)
      limit += int'(rows[k].cycles) + 2 + N_PERF_EVENTS;
    limit += 40;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int k = 0; k < rows.size(); k++)
      run_row(k);
    $display("summary: %0d tests run, %0d errors", rows.size(), errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== hdl/csr_top.sv ====
`timescale 1ns/1ns

module csr_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [3:0]                       core_id_i,
  input  logic [5:0]                       cluster_id_i,
  input  csr_pkg::csr_req_t                csr_req_i,
  input  csr_pkg::exc_ctrl_t               exc_ctrl_i,
  input  csr_pkg::pipe_status_t            pipe_status_i,
  input  logic [csr_pkg::N_EXT_EVENTS-1:0] ext_events_i,
  output csr_pkg::csr_data_t               csr_rdata_o,
  output logic                             irq_enable_o,
  output csr_pkg::csr_data_t               mepc_o
);
  import csr_pkg::*;

  // machine register side
  logic [1:0] mstatus;
  csr_data_t  mepc;
  cause_t     mcause;
  logic       mreg_we;
  csr_addr_t  mreg_addr;
  csr_data_t  mreg_wdata;

  // counter side
  logic       perf_hit;
  csr_data_t  perf_rdata;
  perf_vec_t  perf_events;

  //////////////////////////////////////////////////
  // machine registers
  //////////////////////////////////////////////////

  csr_access_decode u_decode (
    .req_i        (csr_req_i),
    .mstatus_i    (mstatus),
    .mepc_i       (mepc),
    .mcause_i     (mcause),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .perf_hit_i   (perf_hit),
    .perf_rdata_i (perf_rdata),
    .rdata_o      (csr_rdata_o),
    .mreg_we_o    (mreg_we),
    .mreg_addr_o  (mreg_addr),
    .mreg_wdata_o (mreg_wdata)
  );

  csr_machine_regs u_mregs (
    .clk          (clk),
    .rst_n        (rst_n),
    .we_i         (mreg_we),
    .addr_i       (mreg_addr),
    .wdata_i      (mreg_wdata),
    .exc_i        (exc_ctrl_i),
    .mstatus_o    (mstatus),
    .mepc_o       (mepc),
    .mcause_o     (mcause),
    .irq_enable_o (irq_enable_o)
  );

  assign mepc_o = mepc;   // to the pc mux for mret

  //////////////////////////////////////////////////
  // performance counters
  //////////////////////////////////////////////////

  perf_event_select u_evsel (
    .clk      (clk),
    .rst_n    (rst_n),
    .pipe_i   (pipe_status_i),
    .ext_i    (ext_events_i),
    .events_o (perf_events)
  );

  perf_counters u_perf (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (csr_req_i),
    .events_i (perf_events),
    .hit_o    (perf_hit),
    .rdata_o  (perf_rdata)
  );

endmodule

// ==== hdl/perf_counters.sv ====
`timescale 1ns/1ns

module perf_counters (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_req_t  req_i,
  input  csr_pkg::perf_vec_t events_i,
  output logic               hit_o,
  output csr_pkg::csr_data_t rdata_o
);
  import csr_pkg::*;

  perf_vec_t  pcer_q;    // per-event enable
  perf_vec_t  pcer_n;
  logic [1:0] pcmr_q;    // [0] global enable, [1] saturate
  logic [1:0] pcmr_n;
  perf_vec_t  inc;
  perf_vec_t  inc_q;     // increment, one cycle behind the event

  csr_data_t [N_PERF_EVENTS-1:0] cnt_q;
  csr_data_t [N_PERF_EVENTS-1:0] cnt_n;

  logic       is_pcer;
  logic       is_pcmr;
  logic       is_pccr;
  logic       pccr_all;  // 0x79F alias
  logic [4:0] pccr_idx;
  logic       wr_op;
  csr_data_t  pcer_wr;
  csr_data_t  pcmr_wr;

  // set and clear act on the register's current value
  function automatic csr_data_t apply_op(csr_op_t op, csr_data_t wdata, csr_data_t cur);
    csr_data_t res;
    case (op)
      CSR_OP_WRITE: res = wdata;
      CSR_OP_SET:   res = cur | wdata;
      CSR_OP_CLEAR: res = cur & ~wdata;
      default:      res = cur;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////

  assign pccr_idx = req_i.addr[4:0];
  assign wr_op    = (req_i.op != CSR_OP_NONE);

  always_comb
  begin
    is_pcer  = 1'b0;
    is_pcmr  = 1'b0;
    is_pccr  = 1'b0;
    pccr_all = 1'b0;
    rdata_o  = '0;

    if (req_i.access)
    begin
      if (req_i.addr == ADDR_PCER)
      begin
        is_pcer = 1'b1;
        rdata_o = {{(XLEN-N_PERF_EVENTS){1'b0}}, pcer_q};
      end
      else if (req_i.addr == ADDR_PCMR)
      begin
        is_pcmr = 1'b1;
        rdata_o = {{(XLEN-2){1'b0}}, pcmr_q};
      end
      else if (req_i.addr == ADDR_PCCR_ALL)
      begin
        is_pccr  = 1'b1;   // reads as zero
        pccr_all = 1'b1;
      end
      else if (req_i.addr[11:5] == PCCR_BASE_HI)
      begin
        // only implemented counters hit
        for (int i = 0; i < N_PERF_EVENTS; i++)
        begin
          if (pccr_idx == i[4:0])
          begin
            is_pccr = 1'b1;
            rdata_o = cnt_q[i];
          end
        end
      end
    end
  end

  assign hit_o = is_pcer | is_pcmr | is_pccr;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  assign inc = events_i & pcer_q & {N_PERF_EVENTS{pcmr_q[0]}};

  assign pcer_wr = apply_op(req_i.op, req_i.wdata, {{(XLEN-N_PERF_EVENTS){1'b0}}, pcer_q});
  assign pcmr_wr = apply_op(req_i.op, req_i.wdata, {{(XLEN-2){1'b0}}, pcmr_q});
  assign pcer_n  = (is_pcer && wr_op) ? pcer_wr[N_PERF_EVENTS-1:0] : pcer_q;
  assign pcmr_n  = (is_pcmr && wr_op) ? pcmr_wr[1:0] : pcmr_q;

  always_comb
  begin
    for (int i = 0; i < N_PERF_EVENTS; i++)
    begin
      cnt_n[i] = cnt_q[i];
      // hold at all ones when saturating
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + csr_data_t'(1);
      // csr access beats a pending increment
      if (is_pccr && wr_op && (pccr_all || (pccr_idx == i[4:0])))
        cnt_n[i] = apply_op(req_i.op, req_i.wdata, cnt_q[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pcer_q <= '0;
      pcmr_q <= 2'b11;   // enabled, saturating
      inc_q  <= '0;
      cnt_q  <= '0;
    end
    else
    begin
      pcer_q <= pcer_n;
      pcmr_q <= pcmr_n;
      inc_q  <= inc;
      cnt_q  <= cnt_n;
    end
  end

endmodule

// ==== hdl/perf_event_select.sv ====
`timescale 1ns/1ns

module perf_event_select (
  input  logic                                clk,
  input  logic                                rst_n,
  input  csr_pkg::pipe_status_t               pipe_i,
  input  logic [csr_pkg::N_EXT_EVENTS-1:0]    ext_i,
  output csr_pkg::perf_vec_t                  events_o
);
  import csr_pkg::*;

  logic id_valid_q;   // id handshake of previous cycle

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      id_valid_q <= 1'b0;
    else
      id_valid_q <= pipe_i.id_valid;
  end

  //////////////////////////////////////////////////
  // event qualification
  //////////////////////////////////////////////////

  always_comb
  begin
    events_o                  = '0;
    events_o[EV_CYCLES]       = 1'b1;
    events_o[EV_INSTR]        = pipe_i.id_valid & pipe_i.is_decoding;
    events_o[EV_LD_STALL]     = pipe_i.ld_stall & id_valid_q;   // load-use hazard
    events_o[EV_JR_STALL]     = pipe_i.jr_stall & id_valid_q;
    events_o[EV_IMISS]        = pipe_i.imiss & ~pipe_i.pc_set;  // skip redirects
    events_o[EV_LOAD]         = pipe_i.mem_load;
    events_o[EV_STORE]        = pipe_i.mem_store;
    events_o[EV_JUMP]         = pipe_i.jump & id_valid_q;
    events_o[EV_BRANCH]       = pipe_i.branch & id_valid_q;
    events_o[EV_BRANCH_TAKEN] = pipe_i.branch & pipe_i.branch_taken & id_valid_q;
    events_o[EV_COMPRESSED]   = pipe_i.id_valid & pipe_i.is_decoding & pipe_i.is_compressed;

    // external sources sit above the built-in ones
    for (int i = 0; i < N_EXT_EVENTS; i++)
      events_o[N_PERF_EVENTS-N_EXT_EVENTS+i] = ext_i[i];
  end

endmodule

// ==== hdl/csr_machine_regs.sv ====
`timescale 1ns/1ns

module csr_machine_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we_i,
  input  csr_pkg::csr_addr_t addr_i,
  input  csr_pkg::csr_data_t wdata_i,    // already op-resolved
  input  csr_pkg::exc_ctrl_t exc_i,
  output logic [1:0]         mstatus_o,  // {mpie, mie}
  output csr_pkg::csr_data_t mepc_o,
  output csr_pkg::cause_t    mcause_o,
  output logic               irq_enable_o
);
  import csr_pkg::*;

  logic [1:0] mstatus_q;
  logic [1:0] mstatus_n;
  csr_data_t  mepc_q;
  csr_data_t  mepc_n;
  cause_t     mcause_q;
  cause_t     mcause_n;

  logic       mie;
  logic       mpie;
  logic       exc_save;   // any save source

  assign mie      = mstatus_q[0];
  assign mpie     = mstatus_q[1];
  assign exc_save = exc_i.save_if | exc_i.save_id | exc_i.save_branch;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb
  begin
    mstatus_n = mstatus_q;
    mepc_n    = mepc_q;
    mcause_n  = mcause_q;

    // csr writes first, exception logic overrides below
    if (we_i)
    begin
      case (addr_i)
        ADDR_MSTATUS: mstatus_n = {wdata_i[7], wdata_i[3]};
        ADDR_MEPC:    mepc_n    = wdata_i;
        ADDR_MCAUSE:  mcause_n  = {wdata_i[31], wdata_i[4:0]};
        default:      ;   // read-only or unmapped
      endcase
    end

    if (exc_save)
    begin
      mstatus_n = {mie, 1'b0};   // stack ie, disable irqs

      // pc selection, load error first
      if (exc_i.load_event)
      begin
        mepc_n = exc_i.pc_id;
      end
      else if (exc_i.save_branch)
      begin
        mepc_n = exc_i.branch_target;
      end
      else if (exc_i.save_if)
      begin
        mepc_n = exc_i.pc_if;
      end
      else
      begin
        mepc_n = exc_i.pc_id;
      end
    end

    if (exc_i.save_cause)
      mcause_n = exc_i.cause;   // beats a csr write

    // mret: unstack ie
    if (exc_i.restore)
      mstatus_n = {mpie, mpie};
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end
    else
    begin
      mstatus_q <= mstatus_n;
      mepc_q    <= mepc_n;
      mcause_q  <= mcause_n;
    end
  end

  assign mstatus_o    = mstatus_q;
  assign mepc_o       = mepc_q;
  assign mcause_o     = mcause_q;
  assign irq_enable_o = mie;   // follows mie directly

endmodule

// ==== hdl/csr_access_decode.sv ====
`timescale 1ns/1ns

module csr_access_decode (
  input  csr_pkg::csr_req_t  req_i,
  input  logic [1:0]         mstatus_i,     // {mpie, mie}
  input  csr_pkg::csr_data_t mepc_i,
  input  csr_pkg::cause_t    mcause_i,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  logic               perf_hit_i,    // address owned by counter unit
  input  csr_pkg::csr_data_t perf_rdata_i,
  output csr_pkg::csr_data_t rdata_o,
  output logic               mreg_we_o,
  output csr_pkg::csr_addr_t mreg_addr_o,
  output csr_pkg::csr_data_t mreg_wdata_o
);
  import csr_pkg::*;

  csr_data_t mreg_rdata;   // machine side read word

  //////////////////////////////////////////////////
  // read word
  //////////////////////////////////////////////////

  always_comb
  begin
    mreg_rdata = '0;   // unmapped reads as zero
    case (req_i.addr)
      // only mpie and mie implemented
      ADDR_MSTATUS: mreg_rdata = {24'b0, mstatus_i[1], 3'b0, mstatus_i[0], 3'b0};
      ADDR_MISA:    mreg_rdata = '0;   // not reported
      ADDR_MEPC:    mreg_rdata = mepc_i;
      ADDR_MCAUSE:  mreg_rdata = {mcause_i[5], 26'b0, mcause_i[4:0]};
      ADDR_MIMPID:  mreg_rdata = MIMPID_VALUE;
      // hart id built from cluster and core ids
      ADDR_MHARTID: mreg_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:      mreg_rdata = '0;
    endcase
  end

  // counter unit owns its own window
  assign rdata_o = perf_hit_i ? perf_rdata_i : mreg_rdata;

  //////////////////////////////////////////////////
  // op resolution
  //////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.op)
      CSR_OP_SET:   mreg_wdata_o = mreg_rdata | req_i.wdata;
      CSR_OP_CLEAR: mreg_wdata_o = mreg_rdata & ~req_i.wdata;
      default:      mreg_wdata_o = req_i.wdata;   // write, none ignored by strobe
    endcase
  end

  // strobe only for machine side accesses
  assign mreg_we_o   = req_i.access && (req_i.op != CSR_OP_NONE) && !perf_hit_i;
  assign mreg_addr_o = req_i.addr;

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int XLEN = 32;

  typedef logic [11:0]     csr_addr_t;   // csr address space
  typedef logic [XLEN-1:0] csr_data_t;   // one csr data word
  typedef logic [1:0]      csr_op_t;
  typedef logic [5:0]      cause_t;      // [5] irq flag, [4:0] code

  // csr operations
  localparam csr_op_t CSR_OP_NONE  = 2'd0;
  localparam csr_op_t CSR_OP_WRITE = 2'd1;
  localparam csr_op_t CSR_OP_SET   = 2'd2;
  localparam csr_op_t CSR_OP_CLEAR = 2'd3;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
  localparam csr_addr_t ADDR_MISA     = 12'h301;
  localparam csr_addr_t ADDR_MEPC     = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
  localparam csr_addr_t ADDR_MIMPID   = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID  = 12'hF14;
  localparam csr_addr_t ADDR_PCER     = 12'h7A0;
  localparam csr_addr_t ADDR_PCMR     = 12'h7A1;
  localparam csr_addr_t ADDR_PCCR_ALL = 12'h79F;   // write-all alias
  localparam logic [6:0] PCCR_BASE_HI = 7'b0111100; // 0x780..0x79F window

  localparam csr_data_t MIMPID_VALUE = 32'h0000_8000;

  //////////////////////////////////////////////////
  // performance events
  //////////////////////////////////////////////////

  localparam int EV_CYCLES       = 0;
  localparam int EV_INSTR        = 1;
  localparam int EV_LD_STALL     = 2;
  localparam int EV_JR_STALL     = 3;
  localparam int EV_IMISS        = 4;
  localparam int EV_LOAD         = 5;
  localparam int EV_STORE        = 6;
  localparam int EV_JUMP         = 7;
  localparam int EV_BRANCH       = 8;
  localparam int EV_BRANCH_TAKEN = 9;
  localparam int EV_COMPRESSED   = 10;

  localparam int N_EXT_EVENTS  = 2;
  localparam int N_PERF_EVENTS = EV_COMPRESSED + 1 + N_EXT_EVENTS;   // 13

  typedef logic [N_PERF_EVENTS-1:0] perf_vec_t;   // one bit per counter

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic      access;
    csr_addr_t addr;
    csr_op_t   op;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    logic      save_if;
    logic      save_id;
    logic      save_branch;
    logic      load_event;    // data load error in ex, forces pc_id
    logic      restore;       // mret
    logic      save_cause;
    cause_t    cause;
    csr_data_t pc_if;
    csr_data_t pc_id;
    csr_data_t branch_target;
  } exc_ctrl_t;

  typedef struct packed {
    logic id_valid;
    logic is_compressed;
    logic is_decoding;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } pipe_status_t;

endpackage
